// ==== dip_display_settings.svh ====
/* Build-time constants for the DIP switch display test.
   Include in any RTL file that needs debounce, scan or digit sizing */
`ifndef DIP_DISPLAY_SETTINGS_SVH
`define DIP_DISPLAY_SETTINGS_SVH

// Cycles a synchronized switch value must hold before acceptance
// Fits a 5-bit stability counter
`define DEBOUNCE_CYCLES 16

// Cycles each digit stays selected during the scan
`define SCAN_CYCLES 8

// Digits on the multiplexed display
// Low 2 show the switch value, the rest the change count
`define NUM_DIGITS 6

`endif

// ==== dip_display_pkg.sv ====
/* Shared types for the DIP switch display test.
   Modules pull these in with a wildcard import in their header */
`include "dip_display_settings.svh"

package dip_display_pkg;

	// One BCD nibble, 10 to 15 display blank
	typedef logic [3:0] bcd_t;

	// Full display contents, digit 0 is the rightmost
	typedef bcd_t [`NUM_DIGITS-1:0] display_word_t;

	// Debounced switch result
	typedef struct packed {
		logic [3:0] value;   // Accepted switch value
		logic       changed; // One-cycle pulse on a new value
	} switch_state_t;

	// Pins toward the display, all active low
	typedef struct packed {
		logic [7:0]             segments; // dp g f e d c b a
		logic [`NUM_DIGITS-1:0] scan;     // One bit per digit
	} seg_drive_t;

endpackage

// ==== dip_sampler.sv ====
/* Synchronizes and debounces the four DIP switch lines.
   Drives the LEDs and pulses changed when a new value is accepted */
`timescale 1ns/1ns
`include "dip_display_settings.svh"

module dip_sampler
	import dip_display_pkg::*;
(
	input  logic          CLOCK,
	input  logic          RST_n,
	input  logic [3:0]    dip_key, // Raw switch lines
	output logic [3:0]    led,
	output switch_state_t switch
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [3:0]       sync_meta;  // First flop, may go metastable
	logic [3:0]       sync_q;     // Synchronized switch value
	logic [3:0]       cand_q;     // Last cycle's synchronized value
	logic [CNT_W-1:0] stable_cnt; // Cycles the candidate has held
	logic             seen_q;     // Set after the first acceptance
	logic             stable;
	logic             accept;

	// Held long enough and either new or the very first value
	assign stable = (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES));
	assign accept = stable && (!seen_q || (cand_q != switch.value));

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			sync_meta  <= '0;
			sync_q     <= '0;
			cand_q     <= '0;
			stable_cnt <= '0;
			seen_q     <= 1'b0;
			switch     <= '0;
		end
		else
		begin
			sync_meta <= dip_key;
			sync_q    <= sync_meta;
			cand_q    <= sync_q;
			// Any movement restarts the count
			if (sync_q != cand_q)
				stable_cnt <= CNT_W'(1);
			else if (!stable)
				stable_cnt <= stable_cnt + CNT_W'(1); // Saturates at the limit
			switch.changed <= accept; // Single cycle, accept drops once value catches up
			if (accept)
			begin
				switch.value <= cand_q;
				seen_q       <= 1'b1;
			end
		end
	end

	assign led = switch.value; // LEDs follow the accepted value

endmodule

// ==== display_word_builder.sv ====
/* Builds the six display digits from accepted switch values.
   Low two digits show the value 00 to 15, upper digits count changes */
`timescale 1ns/1ns
`include "dip_display_settings.svh"

module display_word_builder
	import dip_display_pkg::*;
(
	input  logic          CLOCK,
	input  logic          RST_n,
	input  switch_state_t switch,
	output display_word_t word
);

	localparam int CNT_DIGITS = `NUM_DIGITS - 2; // Digits left for the counter

	typedef bcd_t [CNT_DIGITS-1:0] count_t;

	bcd_t [1:0] value_q; // Tens and units of the switch value
	count_t     count_q; // Decimal change counter

	// Switch value as tens and units
	function automatic logic [7:0] to_bcd(input logic [3:0] v);
		case (v) inside
			[4'd0:4'd9]: to_bcd = {4'd0, v};
			default:     to_bcd = {4'd1, v - 4'd10}; // 10 to 15
		endcase
	endfunction

	// Add one with decimal carry, 9999 rolls to 0000
	function automatic count_t bcd_inc(input count_t cur);
		count_t nxt;
		logic   carry;
		nxt   = cur;
		carry = 1'b1;
		for (int i = 0; i < CNT_DIGITS; i++)
		begin
			if (carry)
			begin
				if (cur[i] == 4'd9)
					nxt[i] = 4'd0; // Carry moves up
				else
				begin
					nxt[i] = cur[i] + 4'd1;
					carry  = 1'b0;
				end
			end
		end
		return nxt;
	endfunction

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			value_q <= 8'h16; // Nothing accepted yet
			count_q <= '0;
		end
		else if (switch.changed)
		begin
			value_q <= to_bcd(switch.value);
			count_q <= bcd_inc(count_q);
		end
	end

	assign word = {count_q, value_q};

endmodule

// ==== seven_seg_scanner.sv ====
/* Multiplexes the six-digit seven-segment display.
   Steps the active digit every scan period and decodes its BCD nibble */
`timescale 1ns/1ns
`include "dip_display_settings.svh"

module seven_seg_scanner
	import dip_display_pkg::*;
(
	input  logic          CLOCK,
	input  logic          RST_n,
	input  display_word_t word,  // Held level, read at any time
	output seg_drive_t    drive
);

	localparam int PRE_W = $clog2(`SCAN_CYCLES);
	localparam int IDX_W = $clog2(`NUM_DIGITS);

	logic [PRE_W-1:0] pre_cnt;   // Scan period prescaler
	logic [IDX_W-1:0] idx_q;     // Selected digit
	logic             started_q; // First period has elapsed
	logic             tick;

	assign tick = (pre_cnt == PRE_W'(`SCAN_CYCLES - 1));

	// Active-low pattern, dp g f e d c b a
	function automatic logic [7:0] seg_of(input bcd_t d);
		case (d)
			4'd0:    seg_of = 8'hC0;
			4'd1:    seg_of = 8'hF9;
			4'd2:    seg_of = 8'hA4;
			4'd3:    seg_of = 8'hB0;
			4'd4:    seg_of = 8'h99;
			4'd5:    seg_of = 8'h92;
			4'd6:    seg_of = 8'h82;
			4'd7:    seg_of = 8'hF8;
			4'd8:    seg_of = 8'h80;
			4'd9:    seg_of = 8'h90;
			default: seg_of = 8'hFF; // Not a decimal digit, blank
		endcase
	endfunction

	// Prescaler and digit index
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			pre_cnt   <= '0;
			idx_q     <= '0;
			started_q <= 1'b0;
		end
		else if (tick)
		begin
			pre_cnt   <= '0;
			started_q <= 1'b1; // Digit 0 lights from here on
			if (started_q)
			begin
				if (idx_q == IDX_W'(`NUM_DIGITS - 1))
					idx_q <= '0; // Back to the rightmost digit
				else
					idx_q <= idx_q + IDX_W'(1);
			end
		end
		else
			pre_cnt <= pre_cnt + PRE_W'(1);
	end

	// Registered pins, scan and segments move together
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			drive <= '1; // All digits dark
		else if (started_q)
		begin
			drive.scan     <= ~(`NUM_DIGITS'(1) << idx_q);
			drive.segments <= seg_of(word[idx_q]);
		end
		else
			drive <= '1;
	end

endmodule

// ==== dip_display_top.sv ====
/* Top level of the DIP switch display test.
   Joins the switch sampler, the digit builder and the display scanner */
`timescale 1ns/1ns
`include "dip_display_settings.svh"

module dip_display_top
	import dip_display_pkg::*;
(
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic [3:0] dip_key, // Raw switches from the board
	output logic [3:0] led,
	output seg_drive_t drive    // To the display pins
);

	switch_state_t switch; // Accepted value and change pulse
	display_word_t word;   // Six BCD digits

	dip_sampler u_sampler
	(
		.CLOCK   (CLOCK),
		.RST_n   (RST_n),
		.dip_key (dip_key),
		.led     (led),
		.switch  (switch)
	);

	display_word_builder u_builder
	(
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.switch (switch),
		.word   (word)
	);

	seven_seg_scanner u_scanner
	(
		.CLOCK (CLOCK),
		.RST_n (RST_n),
		.word  (word),
		.drive (drive)
	);

endmodule

// ==== tb_dip_display.sv ====
/* Directed testbench for the DIP switch display top level.
   Runs reset, debounce, glitch, counting, scan and sweep tests */
`timescale 1ns/1ns
`include "dip_display_settings.svh"

module tb_dip_display
	import dip_display_pkg::*;
();

	localparam int PERIOD   = 100;
	localparam int DEB      = `DEBOUNCE_CYCLES;
	localparam int SCAN     = `SCAN_CYCLES;
	localparam int DIGITS   = `NUM_DIGITS;
	localparam int SETTLE   = 2 + DEB + 6;       // Sync, debounce, word and pin registers
	localparam int READ_MAX = DIGITS * SCAN + 2; // Longest wait for one digit
	localparam int SEQ_LEN  = 8;                 // Random values in the counting test

	// Worst case length of all tests in clock cycles
	localparam int RUN_CYCLES = 4
		+ 6 * READ_MAX                                     // Reset state
		+ (SETTLE + 2) + 2 * READ_MAX                      // Accepted value
		+ DEB + (SETTLE + 2) + 6 * READ_MAX                // Glitch rejection
		+ SEQ_LEN * (SETTLE + 2) + 4 * READ_MAX            // Change counting
		+ DIGITS * SCAN                                    // Scan rotation
		+ 16 * (SETTLE + 2 + 2 * READ_MAX) + 4 * READ_MAX; // Full sweep
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * PERIOD;

	logic              CLOCK;
	logic              RST_n;
	logic [3:0]        dip_key;
	logic [3:0]        led;
	seg_drive_t        drive;
	logic              jitter;   // Toggles the switches so nothing settles
	logic [15:0]       lfsr;
	int                errors;
	int                accepted; // Expected change count
	logic [3:0]        last_val; // Expected accepted value
	logic              seen;     // First acceptance has happened

	dip_display_top dut
	(
		.CLOCK   (CLOCK),
		.RST_n   (RST_n),
		.dip_key (dip_key),
		.led     (led),
		.drive   (drive)
	);

	always #(PERIOD / 2) CLOCK = ~CLOCK;

	// Toggle every cycle while jitter is set
	always @(posedge CLOCK)
		if (jitter)
			dip_key <= ~dip_key;

	// Active-low patterns in dp g f e d c b a order
	function automatic logic [7:0] seg_pattern(input int d);
		case (d)
			0:       return 8'hC0;
			1:       return 8'hF9;
			2:       return 8'hA4;
			3:       return 8'hB0;
			4:       return 8'h99;
			5:       return 8'h92;
			6:       return 8'h82;
			7:       return 8'hF8;
			8:       return 8'h80;
			9:       return 8'h90;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // Galois form of x^16+x^14+x^13+x^11+1
	endfunction

	// Decimal digit pos of a count
	function automatic int count_digit(input int count, input int pos);
		int div;
		div = 1;
		for (int i = 0; i < pos; i++)
			div = div * 10;
		return (count / div) % 10;
	endfunction

	// Lowest active digit or -1 when dark
	function automatic int scan_index(input logic [DIGITS-1:0] scan);
		for (int i = 0; i < DIGITS; i++)
			if (!scan[i])
				return i;
		return -1;
	endfunction

	task automatic pick_nibble(output logic [3:0] v);
		v = '0;
		for (int i = 0; i < 4; i++)
		begin
			lfsr = lfsr_step(lfsr); // One step per bit
			v    = {v[2:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	// Polls the scan on falling edges until digit d lights
	task automatic wait_digit(input int d, output logic found);
		logic [DIGITS-1:0] want;
		want    = '1;
		want[d] = 1'b0;
		found   = 1'b0;
		for (int i = 0; i < READ_MAX && !found; i++)
		begin
			@(negedge CLOCK);
			if (drive.scan == want)
				found = 1'b1;
		end
	endtask

	task automatic read_digit(input string name, input int d, input int expected);
		logic found;
		wait_digit(d, found);
		if (!found)
		begin
			$display("%s: digit %0d was never selected by the scan", name, d);
			errors++;
		end
		else
			check($sformatf("%s digit %0d", name, d), seg_pattern(expected), drive.segments);
	endtask

	task automatic drive_hold(input logic [3:0] v, input int cycles);
		@(posedge CLOCK);
		dip_key <= v;
		repeat (cycles) @(posedge CLOCK);
	endtask

	// Holds a value until accepted and tracks the expected count
	task automatic apply_value(input logic [3:0] v);
		drive_hold(v, SETTLE);
		if (!seen || v != last_val)
			accepted++;
		seen     = 1'b1;
		last_val = v;
		@(negedge CLOCK);
	endtask

	task automatic check_value(input string name, input logic [3:0] v);
		check($sformatf("%s led", name), v, led);
		read_digit(name, 1, v / 10);
		read_digit(name, 0, v % 10);
	endtask

	task automatic check_counter(input string name);
		for (int d = 2; d < DIGITS; d++)
			read_digit(name, d, count_digit(accepted, d - 2));
	endtask

	task automatic test_reset_state();
		@(negedge CLOCK);
		check("reset_state led", 0, led);
		check("reset_state scan", {DIGITS{1'b1}}, drive.scan);
		check("reset_state segments", 8'hFF, drive.segments);
		read_digit("reset_state", 0, 6); // The 16 marker
		read_digit("reset_state", 1, 1);
		for (int d = 2; d < DIGITS; d++)
			read_digit("reset_state", d, 0);
		jitter = 1'b0;
	endtask

	task automatic test_accepted_value();
		apply_value(4'd12);
		check_value("accepted_value", 4'd12);
	endtask

	task automatic test_glitch_rejection();
		logic [3:0] cur;
		cur = last_val;
		drive_hold(cur ^ 4'h5, DEB - 4); // Too short to be accepted
		drive_hold(cur, SETTLE);
		@(negedge CLOCK);
		check_value("glitch_rejection", cur);
		check_counter("glitch_rejection");
	endtask

	task automatic test_change_count();
		logic [3:0] v;
		for (int n = 0; n < SEQ_LEN; n++)
		begin
			pick_nibble(v);
			if (seen && v == last_val)
				continue; // Would not count as a change
			apply_value(v);
		end
		check_counter("change_count");
	endtask

	task automatic test_scan_rotation();
		logic [DIGITS-1:0] seen_mask;
		int                prev;
		int                idx;
		seen_mask = '0;
		prev      = -1;
		repeat (DIGITS * SCAN)
		begin
			@(negedge CLOCK);
			check("scan_rotation one digit", 1, $countones(~drive.scan));
			idx = scan_index(drive.scan);
			if (idx >= 0 && prev >= 0 && idx != prev)
				check("scan_rotation order", (prev + 1) % DIGITS, idx);
			if (idx >= 0)
				seen_mask[idx] = 1'b1;
			prev = idx;
		end
		check("scan_rotation coverage", {DIGITS{1'b1}}, seen_mask);
	endtask

	task automatic test_full_sweep();
		for (int v = 0; v < 16; v++)
		begin
			apply_value(v[3:0]);
			check_value("full_sweep", v[3:0]);
		end
		check_counter("full_sweep");
	endtask

	initial
	begin
		CLOCK    = 1'b0;
		RST_n    = 1'b0;
		dip_key  = 4'h0;
		jitter   = 1'b1;
		lfsr     = 16'd22493;
		errors   = 0;
		accepted = 0;
		last_val = 4'h0;
		seen     = 1'b0;
		repeat (3) @(posedge CLOCK);
		RST_n <= 1'b1;
		test_reset_state();
		test_accepted_value();
		test_glitch_rejection();
		test_change_count();
		test_scan_rotation();
		test_full_sweep();
		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Ends a hung run
	initial
	begin
		#(WATCHDOG_NS);
		$display("Run hung, the watchdog expired before the tests finished, %0d errors", errors);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
dip_display_pkg.sv
dip_sampler.sv
display_word_builder.sv
seven_seg_scanner.sv
dip_display_top.sv
tb_dip_display.sv

// ==== Bender.yml ====
package:
  name: dip_display

export_include_dirs:
  - .

sources:
  - dip_display_pkg.sv
  - dip_sampler.sv
  - display_word_builder.sv
  - seven_seg_scanner.sv
  - dip_display_top.sv
  - target: test
    files:
      - tb_dip_display.sv
